/* verilog/smc_size_pkg.sv */
package smc_size_pkg;

  // width of the internal word and of the widest external bus
  localparam int data_width = 32;

  // size code, shared by transfer size and external bus size
  typedef logic [1:0] xfer_size_t;

  // transfer size codes, as presented with valid_access
  localparam xfer_size_t xsiz_8  = 2'd0;
  localparam xfer_size_t xsiz_16 = 2'd1;
  localparam xfer_size_t xsiz_32 = 2'd2;

  // external bus size codes, same values as the transfer codes
  localparam xfer_size_t bsiz_8  = 2'd0;
  localparam xfer_size_t bsiz_16 = 2'd1;
  localparam xfer_size_t bsiz_32 = 2'd2;

  // accesses still to come after the current one
  // 3 is the most a 32 bit transfer on an 8 bit bus needs
  typedef logic [1:0] access_cnt_t;

  //--------------------------------------------------------------------
  // one data word, seen either as byte lanes or as halfword lanes
  //--------------------------------------------------------------------
  // lane 0 is the least significant in both views
  // byte lanes carry 8 bit beats
  // halfword lanes carry 16 bit beats and the replicated results
  typedef union packed
  {
    logic [3:0][7:0]  bytes;   // bytes[3] = bits 31:24
    logic [1:0][15:0] halves;  // halves[1] = bits 31:16
  } data_word_u;

endpackage

/* verilog/smc_state_pkg.sv */
package smc_state_pkg;

  // state code of the controller FSM, one hot
  // bit 4 belongs to states this block never looks at
  typedef logic [4:0] smc_state_t;

  //--------------------------------------------------------------------
  // states seen by the multiple access logic
  //--------------------------------------------------------------------
  localparam smc_state_t smc_idle  = 5'b00001;  // no transfer
  localparam smc_state_t smc_le    = 5'b00010;  // address latch enable
  localparam smc_state_t smc_rw    = 5'b00100;  // external read or write
  localparam smc_state_t smc_store = 5'b01000;  // read data store

  // the access counter only moves when the FSM goes on to another
  // external access, so leaving for store or idle holds it

endpackage

/* verilog/smc_access_count.sv */
`timescale 1ns/100ps

module smc_access_count
#(
  parameter smc_size_pkg::xfer_size_t bus_size = smc_size_pkg::bsiz_8
)
(
  input  logic                       sys_clk4,
  input  logic                       n_sys_reset4,
  input  logic                       valid_access,   // address cycle of a new transfer
  input  smc_size_pkg::xfer_size_t   xfer_size,      // valid with valid_access
  input  logic                       smc_done,       // end of one external access
  input  smc_state_pkg::smc_state_t  smc_nextstate,
  output smc_size_pkg::xfer_size_t   r_xfer_size,    // stored transfer size
  output smc_size_pkg::access_cnt_t  r_num_access,   // accesses still to come
  output logic                       mac_done,       // current access is the last
  output smc_size_pkg::xfer_size_t   v_xfer_size     // size valid in every cycle
);

  import smc_size_pkg::*;
  import smc_state_pkg::*;

  access_cnt_t num_accesses;  // load value, accesses minus one
  xfer_size_t  size_diff;     // log2 of bus beats per transfer
  logic        next_access;   // access done and another follows

  //--------------------------------------------------------------------
  // store transfer size
  //--------------------------------------------------------------------
  always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
  begin
    if (!n_sys_reset4)
      r_xfer_size <= xsiz_8;
    else if (valid_access)
      r_xfer_size <= xfer_size;
  end

  // live size in the address cycle, stored size after it
  assign v_xfer_size = valid_access ? xfer_size : r_xfer_size;

  //--------------------------------------------------------------------
  // number of accesses for this transfer
  //--------------------------------------------------------------------
  // transfer bytes over bus bytes, never less than one access
  assign size_diff = xfer_size - bus_size;

  always_comb
  begin
    num_accesses = 2'd0;            // one access
    if (xfer_size > bus_size)
    begin
      case (size_diff)
        2'd1:    num_accesses = 2'd1;  // two accesses
        default: num_accesses = 2'd3;  // four accesses
      endcase
    end
  end

  // count down only when the FSM heads into another access
  assign next_access = smc_done && (smc_nextstate != smc_store) &&
                       (smc_nextstate != smc_idle);

  always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
  begin
    if (!n_sys_reset4)
      r_num_access <= 2'd0;
    else if (valid_access)
      r_num_access <= num_accesses;     // new transfer wins
    else if (next_access)
      r_num_access <= r_num_access - 2'd1;
  end

  // last access once the count is used up, also true when idle
  assign mac_done = (r_num_access == 2'd0);

endmodule

/* verilog/smc_read_assemble.sv */
`timescale 1ns/100ps

module smc_read_assemble
#(
  parameter smc_size_pkg::xfer_size_t bus_size = smc_size_pkg::bsiz_8
)
(
  input  logic                                sys_clk4,
  input  logic                                n_sys_reset4,
  input  logic                                latch_data,    // external read data valid
  input  logic [smc_size_pkg::data_width-1:0] data_smc,      // external read data
  input  smc_size_pkg::xfer_size_t            r_xfer_size,   // stored transfer size
  input  smc_size_pkg::access_cnt_t           r_num_access,  // picks the beat lane
  output logic [smc_size_pkg::data_width-1:0] read_data      // word to the internal bus
);

  import smc_size_pkg::*;

  data_word_u held_word;    // beats of the transfer so far
  data_word_u beat;         // live beat from the external bus
  data_word_u merged_word;  // held word with the live beat dropped in
  data_word_u src_word;     // word the result is formed from
  xfer_size_t eff_size;     // width of the result before replication

  assign beat = data_smc;

  //--------------------------------------------------------------------
  // place the live beat in its lane
  //--------------------------------------------------------------------
  // lane number is the remaining count, so the first access of a
  // transfer lands in the most significant lane in use
  always_comb
  begin
    merged_word = held_word;
    case (bus_size)
      bsiz_8:
        merged_word.bytes[r_num_access] = beat.bytes[0];
      bsiz_16:
        merged_word.halves[r_num_access[0]] = beat.halves[0];
      default:
        merged_word = beat;           // whole word in one access
    endcase
  end

  // holding register, loads on every latched beat
  always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
  begin
    if (!n_sys_reset4)
      held_word <= '0;
    else if (latch_data)
      held_word <= merged_word;
  end

  //--------------------------------------------------------------------
  // internal read word
  //--------------------------------------------------------------------
  // during the last latch cycle the live beat completes the word
  // combinationally, one cycle before the holding register has it
  assign src_word = latch_data ? merged_word : held_word;

  // a transfer narrower than the bus still returns a full bus beat
  assign eff_size = (r_xfer_size > bus_size) ? r_xfer_size : bus_size;

  always_comb
  begin
    case (eff_size)
      xsiz_8:
        read_data = {4{src_word.bytes[0]}};   // byte on every lane
      xsiz_16:
        read_data = {2{src_word.halves[0]}};  // halfword on both halves
      default:
        read_data = src_word;
    endcase
  end

  // 8 bit bus, 16 bit transfer:
  //   count 1 beat -> bytes[1], count 0 beat -> bytes[0]
  //   result halves[0] = {first, second}, replicated
  // 8 bit bus, 32 bit transfer:
  //   counts 3..0 fill bytes[3]..bytes[0], first beat on top
  // lanes above the transfer keep old data and are never shown

endmodule

/* verilog/smc_write_lane.sv */
`timescale 1ns/100ps

module smc_write_lane
#(
  parameter smc_size_pkg::xfer_size_t bus_size = smc_size_pkg::bsiz_8
)
(
  input  logic [smc_size_pkg::data_width-1:0] write_data,    // held by the AHB side
  input  smc_size_pkg::access_cnt_t           r_num_access,  // picks the slice
  output logic [smc_size_pkg::data_width-1:0] smc_data       // data to the external bus
);

  import smc_size_pkg::*;

  data_word_u wr_word;  // write word split into lanes

  assign wr_word = write_data;

  //--------------------------------------------------------------------
  // slice for the current access
  //--------------------------------------------------------------------
  // remaining count doubles as lane number, highest lane goes first
  // narrow buses drive only the low lanes, the rest stay zero
  always_comb
  begin
    smc_data = '0;
    case (bus_size)
      bsiz_8:
        smc_data[7:0] = wr_word.bytes[r_num_access];        // count 3 -> 31:24
      bsiz_16:
        smc_data[15:0] = wr_word.halves[r_num_access[0]];   // count 1 -> 31:16
      default:
        smc_data = write_data;                              // full width bus
    endcase
  end

  // a narrow transfer on a wide bus has count 0 throughout
  // so it always sends the low lane of the write word

endmodule

/* verilog/smc_mac_lite.sv */
`timescale 1ns/100ps

module smc_mac_lite
#(
  parameter smc_size_pkg::xfer_size_t bus_size = smc_size_pkg::bsiz_8
)
(
  input  logic                                sys_clk4,
  input  logic                                n_sys_reset4,    // async, active low
  input  logic                                valid_access,    // address cycle
  input  smc_size_pkg::xfer_size_t            xfer_size,       // with valid_access
  input  logic                                smc_done,        // access finished
  input  logic [smc_size_pkg::data_width-1:0] data_smc,        // external read data
  input  logic [smc_size_pkg::data_width-1:0] write_data,      // internal write data
  input  smc_state_pkg::smc_state_t           smc_nextstate,   // controller FSM
  input  logic                                latch_data,      // read beat valid
  output smc_size_pkg::access_cnt_t           r_num_access,    // access counter
  output logic                                mac_done,        // last access
  output smc_size_pkg::xfer_size_t            v_xfer_size,     // validated size
  output logic [smc_size_pkg::data_width-1:0] read_data,       // to internal bus
  output logic [smc_size_pkg::data_width-1:0] smc_data         // to external bus
);

  import smc_size_pkg::*;

  xfer_size_t r_xfer_size;  // stored size for the read path

  //--------------------------------------------------------------------
  // access counting
  //--------------------------------------------------------------------
  smc_access_count #(
    .bus_size      (bus_size)
  ) u_access_count (
    .sys_clk4      (sys_clk4),
    .n_sys_reset4  (n_sys_reset4),
    .valid_access  (valid_access),
    .xfer_size     (xfer_size),
    .smc_done      (smc_done),
    .smc_nextstate (smc_nextstate),
    .r_xfer_size   (r_xfer_size),
    .r_num_access  (r_num_access),
    .mac_done      (mac_done),
    .v_xfer_size   (v_xfer_size)
  );

  // read beats into one word
  smc_read_assemble #(
    .bus_size      (bus_size)
  ) u_read_assemble (
    .sys_clk4      (sys_clk4),
    .n_sys_reset4  (n_sys_reset4),
    .latch_data    (latch_data),
    .data_smc      (data_smc),
    .r_xfer_size   (r_xfer_size),
    .r_num_access  (r_num_access),
    .read_data     (read_data)
  );

  // write word split into beats, no storage needed
  smc_write_lane #(
    .bus_size      (bus_size)
  ) u_write_lane (
    .write_data    (write_data),
    .r_num_access  (r_num_access),
    .smc_data      (smc_data)
  );

endmodule

/* include/tb_smc_mac_table.svh */
`ifndef TB_SMC_MAC_TABLE_SVH
`define TB_SMC_MAC_TABLE_SVH

// one row per transfer, applied in order with no gap between rows
// columns: read (1) or write (0), size code, write word, expected counter load
localparam int num_rows = 12;

logic        row_read  [0:num_rows-1];  // direction
xfer_size_t  row_size  [0:num_rows-1];  // transfer size code
logic [31:0] row_wdata [0:num_rows-1];  // held write word, unused on reads
access_cnt_t row_count [0:num_rows-1];  // accesses minus one on an 8 bit bus

task automatic set_row(input int idx, input logic rd, input xfer_size_t size,
                       input logic [31:0] wdata, input access_cnt_t cnt);
  begin
    row_read[idx]  = rd;
    row_size[idx]  = size;
    row_wdata[idx] = wdata;
    row_count[idx] = cnt;
  end
endtask

//----------------------------------------------------------------------
// transfer list
//----------------------------------------------------------------------
task automatic load_table;
  begin
    set_row(0,  1'b0, xsiz_32, 32'h1234_5678, 2'd3);  // word write
    set_row(1,  1'b1, xsiz_32, 32'h0000_0000, 2'd3);  // word read after write
    set_row(2,  1'b0, xsiz_16, 32'h0000_abcd, 2'd1);  // halfword write
    set_row(3,  1'b1, xsiz_16, 32'h0000_0000, 2'd1);  // halfword read
    set_row(4,  1'b0, xsiz_8,  32'h0000_00ef, 2'd0);  // single beat
    set_row(5,  1'b1, xsiz_8,  32'h0000_0000, 2'd0);
    set_row(6,  1'b1, xsiz_32, 32'h0000_0000, 2'd3);  // wide read after narrow
    set_row(7,  1'b0, xsiz_32, 32'hdead_beef, 2'd3);
    set_row(8,  1'b1, xsiz_16, 32'h0000_0000, 2'd1);  // stale upper lanes held
    set_row(9,  1'b1, xsiz_8,  32'h0000_0000, 2'd0);
    set_row(10, 1'b0, xsiz_16, 32'ha5a5_c3c3, 2'd1);  // upper half must be ignored
    set_row(11, 1'b0, xsiz_8,  32'h0f1e_2d3c, 2'd0);  // only the low byte goes out
  end
endtask

`endif

/* verification/tb_smc_mac.sv */
`timescale 1ns/100ps

module tb_smc_mac;

  import smc_size_pkg::*;
  import smc_state_pkg::*;

  localparam int half_period = 20;  // 40 ns clock
  localparam int wait_limit  = 16;  // cycles allowed for any wait

  logic        sys_clk4;
  logic        n_sys_reset4;
  logic        valid_access;
  xfer_size_t  xfer_size;
  logic        smc_done;
  logic [31:0] data_smc;
  logic [31:0] write_data;
  smc_state_t  smc_nextstate;
  logic        latch_data;
  access_cnt_t r_num_access;
  logic        mac_done;
  xfer_size_t  v_xfer_size;
  logic [31:0] read_data;
  logic [31:0] smc_data;

  logic [31:0] lfsr_state;  // random source for read beats

  `include "tb_smc_mac_table.svh"

  smc_mac_lite #(
    .bus_size      (bsiz_8)
  ) dut (
    .sys_clk4      (sys_clk4),
    .n_sys_reset4  (n_sys_reset4),
    .valid_access  (valid_access),
    .xfer_size     (xfer_size),
    .smc_done      (smc_done),
    .data_smc      (data_smc),
    .write_data    (write_data),
    .smc_nextstate (smc_nextstate),
    .latch_data    (latch_data),
    .r_num_access  (r_num_access),
    .mac_done      (mac_done),
    .v_xfer_size   (v_xfer_size),
    .read_data     (read_data),
    .smc_data      (smc_data)
  );

  initial
  begin
    sys_clk4 = 1'b0;
    forever #half_period sys_clk4 = ~sys_clk4;
  end

  //--------------------------------------------------------------------
  // helpers
  //--------------------------------------------------------------------
  // galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      lfsr_step = (s >> 1) ^ 32'h8020_0003;
    else
      lfsr_step = s >> 1;
  endfunction

  // one lfsr step per bit with the first bit ending up most significant
  task automatic take_bits(input int n, output logic [31:0] bits);
    int i;
    begin
      bits = '0;
      for (i = 0; i < n; i++)
      begin
        bits       = {bits[30:0], lfsr_state[0]};
        lfsr_state = lfsr_step(lfsr_state);
      end
    end
  endtask

  // first beat lands highest and narrow results repeat on every lane
  function automatic logic [31:0] expected_read(input logic [31:0] beats,
                                                input xfer_size_t size);
    case (size)
      xsiz_8:  expected_read = {4{beats[7:0]}};
      xsiz_16: expected_read = {2{beats[15:0]}};
      default: expected_read = beats;
    endcase
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    begin
      if (actual !== expected)
      begin
        $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        $display("Simulation failed");
        $fatal(1);
      end
    end
  endtask

  // polls at the falling edge where the count is stable
  task automatic wait_count(input access_cnt_t target);
    int cycles;
    begin
      cycles = 0;
      while (r_num_access !== target)
      begin
        if (cycles == wait_limit)
        begin
          $display("timeout at %0t ns: access count never reached %0d", $time, target);
          $display("Simulation failed");
          $fatal(1);
        end
        else
        begin
          cycles++;
          @(negedge sys_clk4);
        end
      end
    end
  endtask

  //--------------------------------------------------------------------
  // one transfer entered right after a rising edge
  //--------------------------------------------------------------------
  task automatic apply_row(input int idx);
    logic        rd;
    xfer_size_t  size;
    logic [31:0] wdata;
    logic [31:0] acc;    // beats so far shifted in from the right
    logic [31:0] beat;
    logic [31:0] junk;   // upper lanes ignored on an 8 bit bus
    int          k;
    begin
      rd    = row_read[idx];
      size  = row_size[idx];
      wdata = row_wdata[idx];
      acc   = '0;
      valid_access <= 1'b1;   // also closes the previous last access
      xfer_size    <= size;
      write_data   <= wdata;
      smc_done     <= 1'b0;
      latch_data   <= 1'b0;
      @(negedge sys_clk4);
      check_value(v_xfer_size, size, "v_xfer_size in address cycle");
      check_value(mac_done, 1'b1, "mac_done before load");
      @(posedge sys_clk4);
      valid_access <= 1'b0;
      xfer_size    <= (size == xsiz_32) ? xsiz_8 : xsiz_32;  // stale bus value
      @(negedge sys_clk4);
      check_value(r_num_access, row_count[idx], "access count after load");
      for (k = row_count[idx]; k >= 0; k--)
      begin
        wait_count(access_cnt_t'(k));
        check_value(mac_done, (k == 0), "mac_done against count");
        check_value(v_xfer_size, size, "stored v_xfer_size");
        if (!rd)
          check_value(smc_data, (wdata >> (8 * k)) & 32'hff, "write lane");
        @(posedge sys_clk4);
        smc_done      <= 1'b1;
        smc_nextstate <= (k == 0) ? smc_idle : smc_rw;
        if (rd)
        begin
          take_bits(8, beat);
          take_bits(24, junk);
          data_smc   <= {junk[23:0], beat[7:0]};
          latch_data <= 1'b1;
          acc = {acc[23:0], beat[7:0]};
        end
        @(negedge sys_clk4);
        if (rd && (k == 0))
          check_value(read_data, expected_read(acc, size), "assembled read word");
        if (k > 0)
        begin
          @(posedge sys_clk4);
          smc_done   <= 1'b0;
          latch_data <= 1'b0;
          @(negedge sys_clk4);
        end
      end
    end
  endtask

  //--------------------------------------------------------------------
  // main sequence
  //--------------------------------------------------------------------
  initial
  begin
    int row;
    n_sys_reset4  = 1'b0;
    valid_access  = 1'b0;
    xfer_size     = xsiz_8;
    smc_done      = 1'b0;
    data_smc      = '0;
    write_data    = 32'h96c3_5a00;  // low byte clear, upper lanes busy
    smc_nextstate = smc_idle;
    latch_data    = 1'b0;
    lfsr_state    = 32'he334_2336;
    load_table();
    repeat (5) @(posedge sys_clk4);
    n_sys_reset4 <= 1'b1;
    @(negedge sys_clk4);
    check_value(mac_done, 1'b1, "mac_done after reset");
    check_value(r_num_access, 2'd0, "access count after reset");
    check_value(smc_data, 32'h0, "smc_data after reset");
    for (row = 0; row < num_rows; row++)
    begin
      @(posedge sys_clk4);
      apply_row(row);
    end
    @(posedge sys_clk4);
    smc_done   <= 1'b0;
    latch_data <= 1'b0;
    @(negedge sys_clk4);
    check_value(mac_done, 1'b1, "mac_done at end");
    check_value(r_num_access, 2'd0, "access count at end");
    $display("Simulation passed");
    $finish;
  end

endmodule

/* list.f */
+incdir+include
verilog/smc_size_pkg.sv
verilog/smc_state_pkg.sv
verilog/smc_access_count.sv
verilog/smc_read_assemble.sv
verilog/smc_write_lane.sv
verilog/smc_mac_lite.sv
verification/tb_smc_mac.sv
